// ==== rtl/sprite_pkg.sv ====
////////////////////////////////////////
// sprite data layout
// field widths, write word positions and entry records
////////////////////////////////////////
`default_nettype none

package sprite_pkg;

	////////////////////////////////////////
	// table geometry
	////////////////////////////////////////
	localparam int NUM_SPRITES   = 32;
	localparam int SPRITE_HEIGHT = 20;     // lines covered below top line

	localparam int X_W   = 10;
	localparam int Y_W   = 9;
	localparam int OFS_W = 9;

	////////////////////////////////////////
	// positions inside the write word
	////////////////////////////////////////
	localparam int WR_DATA_W = 32;
	localparam int OFS_LSB   = 0;
	localparam int Y_LSB     = 9;
	localparam int X_LSB     = 18;         // bits 31:28 unused

	typedef logic [X_W-1:0]   x_t;
	typedef logic [Y_W-1:0]   y_t;
	typedef logic [OFS_W-1:0] ofs_t;

	// one table entry, 29 bits
	typedef struct packed {
		logic valid;
		x_t   x;
		y_t   y;
		ofs_t ofs;
	} sprite_entry_t;

	// pixel under test, 19 bits
	typedef struct packed {
		x_t x;
		y_t y;
	} pixel_t;

endpackage

`default_nettype wire

// ==== rtl/table_pkg.sv ====
////////////////////////////////////////
// table access protocol
// field selectors, entry index and credits
////////////////////////////////////////
`default_nettype none

package table_pkg;

	// codes above FIELD_X are illegal and ignored
	typedef enum logic [3:0] {
		FIELD_OFS = 4'd0,
		FIELD_Y   = 4'd1,
		FIELD_X   = 4'd2
	} field_sel_t;

	typedef logic [4:0] sprite_idx_t;

	////////////////////////////////////////
	// lookup result flow control
	////////////////////////////////////////
	localparam int RESULT_CREDITS = 4;     // results the consumer can hold

	typedef logic [2:0] credit_cnt_t;

endpackage

`default_nettype wire

// ==== rtl/lookup_if.sv ====
////////////////////////////////////////
// first-stage lookup outcome
////////////////////////////////////////
`default_nettype none

interface lookup_if;

	logic                      valid;  // one registered lookup
	logic                      hit;
	table_pkg::sprite_idx_t    index;  // zero on miss
	sprite_pkg::sprite_entry_t entry;  // zero on miss

	modport stage_out (
		output valid,
		output hit,
		output index,
		output entry
	);

	modport stage_in (
		input valid,
		input hit,
		input index,
		input entry
	);

endinterface

`default_nettype wire

// ==== rtl/sprite_regs.sv ====
////////////////////////////////////////
// sprite entry storage
// field-wise writes with one-cycle acknowledge
////////////////////////////////////////
`default_nettype none

module sprite_regs (
	input  wire logic                      clk,
	input  wire logic                      reset,
	input  wire logic                      wr_valid,
	input  wire table_pkg::sprite_idx_t    wr_index,
	input  wire table_pkg::field_sel_t     wr_field,
	input  wire logic [sprite_pkg::WR_DATA_W-1:0] wr_data,
	output logic                           wr_ack,
	output sprite_pkg::sprite_entry_t      entries [sprite_pkg::NUM_SPRITES]
);

	logic [sprite_pkg::NUM_SPRITES-1:0] valid_q;
	sprite_pkg::x_t   x_q   [sprite_pkg::NUM_SPRITES];
	sprite_pkg::y_t   y_q   [sprite_pkg::NUM_SPRITES];
	sprite_pkg::ofs_t ofs_q [sprite_pkg::NUM_SPRITES];
	logic             field_ok;

	always_comb begin
		case (wr_field)
			table_pkg::FIELD_OFS,
			table_pkg::FIELD_Y,
			table_pkg::FIELD_X: field_ok = 1'b1;
			default:            field_ok = 1'b0;  // unknown selector
		endcase
	end

	////////////////////////////////////////
	// field storage
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (wr_valid) begin
			case (wr_field)
				table_pkg::FIELD_OFS:
					ofs_q[wr_index] <= wr_data[sprite_pkg::OFS_LSB +: sprite_pkg::OFS_W];
				table_pkg::FIELD_Y:
					y_q[wr_index] <= wr_data[sprite_pkg::Y_LSB +: sprite_pkg::Y_W];
				table_pkg::FIELD_X:
					x_q[wr_index] <= wr_data[sprite_pkg::X_LSB +: sprite_pkg::X_W];
				default: ;                           // nothing touched
			endcase
		end
	end

	// valid flags and ack
	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= '0;
			wr_ack  <= 1'b0;
		end else begin
			wr_ack <= wr_valid && field_ok;
			if (wr_valid && field_ok)
				valid_q[wr_index] <= 1'b1;        // any legal write arms the entry
		end
	end

	always_comb begin
		for (int i = 0; i < sprite_pkg::NUM_SPRITES; i++) begin
			entries[i].valid = valid_q[i];
			entries[i].x     = x_q[i];
			entries[i].y     = y_q[i];
			entries[i].ofs   = ofs_q[i];
		end
	end

endmodule

`default_nettype wire

// ==== rtl/sprite_match.sv ====
////////////////////////////////////////
// parallel priority compare, stage one
// lowest valid entry covering the pixel wins
////////////////////////////////////////
`default_nettype none

module sprite_match (
	input  wire logic                      clk,
	input  wire logic                      reset,
	input  wire logic                      accept,
	input  wire sprite_pkg::pixel_t        pixel,
	input  wire sprite_pkg::sprite_entry_t entries [sprite_pkg::NUM_SPRITES],
	lookup_if.stage_out                    stage
);

	logic [sprite_pkg::NUM_SPRITES-1:0] hit_vec;
	logic [sprite_pkg::Y_W:0]           y_end [sprite_pkg::NUM_SPRITES];
	logic                               match_hit;
	table_pkg::sprite_idx_t             match_index;
	sprite_pkg::sprite_entry_t          match_entry;

	////////////////////////////////////////
	// per-entry compare
	////////////////////////////////////////
	always_comb begin
		for (int i = 0; i < sprite_pkg::NUM_SPRITES; i++) begin
			// one extra bit so the span end never wraps
			y_end[i] = {1'b0, entries[i].y} +
				(sprite_pkg::Y_W + 1)'(sprite_pkg::SPRITE_HEIGHT);
			hit_vec[i] = entries[i].valid &&
				(entries[i].x == pixel.x) &&
				(pixel.y >= entries[i].y) &&
				({1'b0, pixel.y} < y_end[i]);
		end
	end

	// walk downward so the lowest index is written last
	always_comb begin
		match_hit   = 1'b0;
		match_index = '0;
		match_entry = '0;                       // miss reports zero entry
		for (int i = sprite_pkg::NUM_SPRITES - 1; i >= 0; i--) begin
			if (hit_vec[i]) begin
				match_hit   = 1'b1;
				match_index = table_pkg::sprite_idx_t'(i);
				match_entry = entries[i];
			end
		end
	end

	////////////////////////////////////////
	// stage register
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset)
			stage.valid <= 1'b0;
		else
			stage.valid <= accept;
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			stage.hit   <= match_hit;
			stage.index <= match_index;
			stage.entry <= match_entry;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/sprite_result.sv ====
////////////////////////////////////////
// result stage and credit counter
////////////////////////////////////////
`default_nettype none

module sprite_result (
	input  wire logic              clk,
	input  wire logic              reset,
	input  wire logic              lookup_valid,
	input  wire logic              result_credit,
	lookup_if.stage_in             stage,
	output logic                   accept,
	output logic                   lookup_ready,
	output logic                   result_valid,
	output logic                   result_hit,
	output table_pkg::sprite_idx_t result_index,
	output sprite_pkg::ofs_t       result_offset
);

	table_pkg::credit_cnt_t credit_cnt_q;

	////////////////////////////////////////
	// credits
	////////////////////////////////////////
	assign lookup_ready = (credit_cnt_q != '0);
	assign accept       = lookup_valid && lookup_ready;  // request without credit is dropped

	always_ff @(posedge clk) begin
		if (reset) begin
			credit_cnt_q <= table_pkg::credit_cnt_t'(table_pkg::RESULT_CREDITS);
		end else begin
			case ({accept, result_credit})
				2'b10:   credit_cnt_q <= credit_cnt_q - table_pkg::credit_cnt_t'(1);
				2'b01:   credit_cnt_q <= credit_cnt_q + table_pkg::credit_cnt_t'(1);
				default: credit_cnt_q <= credit_cnt_q;  // none, or take and return together
			endcase
		end
	end

	////////////////////////////////////////
	// second pipeline stage
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset)
			result_valid <= 1'b0;
		else
			result_valid <= stage.valid;
	end

	// only index and offset leave the table
	always_ff @(posedge clk) begin
		if (stage.valid) begin
			result_hit    <= stage.hit;
			result_index  <= stage.index;
			result_offset <= stage.entry.ofs;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/sprite_table.sv ====
////////////////////////////////////////
// sprite coordinate table, top level
// writes by field, two-stage pixel lookup
////////////////////////////////////////
`default_nettype none

module sprite_table (
	input  wire logic                      clk,
	input  wire logic                      reset,
	input  wire logic                      wr_valid,
	input  wire table_pkg::sprite_idx_t    wr_index,
	input  wire table_pkg::field_sel_t     wr_field,
	input  wire logic [sprite_pkg::WR_DATA_W-1:0] wr_data,
	input  wire logic                      lookup_valid,
	input  wire sprite_pkg::x_t            pixel_x,
	input  wire sprite_pkg::y_t            pixel_y,
	input  wire logic                      result_credit,
	output logic                           wr_ack,
	output logic                           lookup_ready,
	output logic                           result_valid,
	output logic                           result_hit,
	output table_pkg::sprite_idx_t         result_index,
	output sprite_pkg::ofs_t               result_offset
);

	sprite_pkg::sprite_entry_t entries [sprite_pkg::NUM_SPRITES];
	sprite_pkg::pixel_t        pixel;
	logic                      accept;

	assign pixel = '{x: pixel_x, y: pixel_y};

	lookup_if u_lookup_if ();

	////////////////////////////////////////
	// storage
	////////////////////////////////////////
	sprite_regs u_sprite_regs (
		.clk      (clk),
		.reset    (reset),
		.wr_valid (wr_valid),
		.wr_index (wr_index),
		.wr_field (wr_field),
		.wr_data  (wr_data),
		.wr_ack   (wr_ack),
		.entries  (entries)
	);

	////////////////////////////////////////
	// lookup pipeline
	////////////////////////////////////////
	sprite_match u_sprite_match (
		.clk     (clk),
		.reset   (reset),
		.accept  (accept),           // from credit logic
		.pixel   (pixel),
		.entries (entries),
		.stage   (u_lookup_if.stage_out)
	);

	sprite_result u_sprite_result (
		.clk           (clk),
		.reset         (reset),
		.lookup_valid  (lookup_valid),
		.result_credit (result_credit),
		.stage         (u_lookup_if.stage_in),
		.accept        (accept),
		.lookup_ready  (lookup_ready),
		.result_valid  (result_valid),
		.result_hit    (result_hit),
		.result_index  (result_index),
		.result_offset (result_offset)
	);

endmodule

`default_nettype wire

// ==== sim/sprite_table_props.sv ====
////////////////////////////////////////
// lookup pipeline and credit properties
////////////////////////////////////////
`default_nettype none

module sprite_table_props (
	input wire logic                   clk,
	input wire logic                   reset,
	input wire logic                   accept,
	input wire logic                   result_credit,
	input wire logic                   lookup_ready,
	input wire logic                   result_valid,
	input wire table_pkg::credit_cnt_t credit_cnt
);

	int fail_count = 0;
	int outstanding;                       // accepted, credit not back yet

	always_ff @(posedge clk) begin
		if (reset)
			outstanding <= 0;
		else
			outstanding <= outstanding + int'(accept) - int'(result_credit);
	end

	a_latency: assert property (@(posedge clk) disable iff (reset)
		accept |-> ##2 result_valid)
	else begin
		fail_count++;
		$error("accepted lookup gave no result two cycles later");
	end

	a_no_spurious: assert property (@(posedge clk) disable iff (reset)
		result_valid |-> $past(accept, 2))
	else begin
		fail_count++;
		$error("result_valid without an accept two cycles earlier");
	end

	a_outstanding: assert property (@(posedge clk) disable iff (reset)
		outstanding <= table_pkg::RESULT_CREDITS &&
		outstanding + int'(credit_cnt) == table_pkg::RESULT_CREDITS)
	else begin
		fail_count++;
		$error("outstanding results %0d out of line with credit count", outstanding);
	end

	// ready only while the consumer still has room
	a_ready: assert property (@(posedge clk) disable iff (reset)
		lookup_ready == (outstanding < table_pkg::RESULT_CREDITS))
	else begin
		fail_count++;
		$error("lookup_ready disagrees with outstanding results %0d", outstanding);
	end

endmodule

bind sprite_result sprite_table_props u_props (
	.clk           (clk),
	.reset         (reset),
	.accept        (accept),
	.result_credit (result_credit),
	.lookup_ready  (lookup_ready),
	.result_valid  (result_valid),
	.credit_cnt    (credit_cnt_q)
);

`default_nettype wire

// ==== sim/tb_sprite_table.sv ====
////////////////////////////////////////
// sprite table testbench
// file-driven writes and lookups, credit return
////////////////////////////////////////
`default_nettype none

module tb_sprite_table;

	localparam int MAX_LINES  = 64;
	localparam int LINE_WORDS = 6;         // op plus five operands

	logic                             clk;
	logic                             reset;
	logic                             wr_valid;
	table_pkg::sprite_idx_t           wr_index;
	table_pkg::field_sel_t            wr_field;
	logic [sprite_pkg::WR_DATA_W-1:0] wr_data;
	logic                             lookup_valid;
	sprite_pkg::x_t                   pixel_x;
	sprite_pkg::y_t                   pixel_y;
	logic                             result_credit;
	logic                             wr_ack;
	logic                             lookup_ready;
	logic                             result_valid;
	logic                             result_hit;
	table_pkg::sprite_idx_t           result_index;
	sprite_pkg::ofs_t                 result_offset;

	logic [31:0] testdata [0:MAX_LINES*LINE_WORDS-1];

	// expected results, oldest first
	logic                   exp_hit_q   [$];
	table_pkg::sprite_idx_t exp_index_q [$];
	sprite_pkg::ofs_t       exp_ofs_q   [$];
	int                     exp_cycle_q [$];

	int     cycle = 0;
	int     timeout_limit = 0;
	int     num_lines = 0;
	int     error_count = 0;
	int     check_count = 0;
	int     owed = 0;                      // results taken, credit not yet returned
	int     credit_wait = 0;
	int     hold_left = 0;
	integer seed = 49;

	sprite_table u_sprite_table (
		.clk           (clk),
		.reset         (reset),
		.wr_valid      (wr_valid),
		.wr_index      (wr_index),
		.wr_field      (wr_field),
		.wr_data       (wr_data),
		.lookup_valid  (lookup_valid),
		.pixel_x       (pixel_x),
		.pixel_y       (pixel_y),
		.result_credit (result_credit),
		.wr_ack        (wr_ack),
		.lookup_ready  (lookup_ready),
		.result_valid  (result_valid),
		.result_hit    (result_hit),
		.result_index  (result_index),
		.result_offset (result_offset)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	always @(posedge clk) cycle <= cycle + 1;

	////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////
	task automatic report_error(input string msg);
		$display("FAILED at time %0t: %s", $time, msg);
		error_count++;
	endtask

	task automatic check_ack(input logic exp_ack);
		check_count++;
		if (wr_ack !== exp_ack)
			report_error($sformatf("wr_ack %b, expected %b", wr_ack, exp_ack));
	endtask

	task automatic check_ready(input logic exp_ready);
		check_count++;
		if (lookup_ready !== exp_ready)
			report_error($sformatf("lookup_ready %b, expected %b", lookup_ready, exp_ready));
	endtask

	task automatic check_result(input logic exp_hit, input table_pkg::sprite_idx_t exp_index,
			input sprite_pkg::ofs_t exp_offset);
		check_count++;
		if (result_hit !== exp_hit || result_index !== exp_index || result_offset !== exp_offset)
			report_error($sformatf("result hit %b index %0d offset %h, expected %b %0d %h",
				result_hit, result_index, result_offset, exp_hit, exp_index, exp_offset));
	endtask

	////////////////////////////////////////
	// consumer side, results and credits
	////////////////////////////////////////
	task automatic take_result();
		int acc_cycle;
		if (exp_hit_q.size() == 0) begin
			$display("result_valid at time %0t with no lookup outstanding", $time);
			error_count++;
		end else begin
			acc_cycle = exp_cycle_q.pop_front();
			if (cycle != acc_cycle + 2)
				report_error($sformatf("result %0d cycles after accept, expected 2",
					cycle - acc_cycle));
			check_result(exp_hit_q.pop_front(), exp_index_q.pop_front(), exp_ofs_q.pop_front());
		end
		owed++;
	endtask

	always @(negedge clk) begin
		result_credit = 1'b0;                  // single-cycle pulses
		if (!reset && result_valid)
			take_result();
		if (hold_left > 0) begin
			hold_left--;
		end else if (owed > 0) begin
			if (credit_wait == 0) begin
				result_credit = 1'b1;
				owed--;
				credit_wait = $unsigned($random(seed)) % 4;
			end else begin
				credit_wait--;
			end
		end
	end

	////////////////////////////////////////
	// operations from the data file
	////////////////////////////////////////
	task automatic write_field(input int base);
		wr_valid = 1'b1;
		wr_index = testdata[base+1][4:0];
		wr_field = table_pkg::field_sel_t'(testdata[base+2][3:0]);
		wr_data  = testdata[base+3];
		@(negedge clk);
		wr_valid = 1'b0;
		check_ack(testdata[base+4][0]);
	endtask

	task automatic issue_lookup(input int base);
		while (!lookup_ready)
			@(negedge clk);
		lookup_valid = 1'b1;
		pixel_x      = testdata[base+1][9:0];
		pixel_y      = testdata[base+2][8:0];
		exp_hit_q.push_back(testdata[base+3][0]);
		exp_index_q.push_back(testdata[base+4][4:0]);
		exp_ofs_q.push_back(testdata[base+5][8:0]);
		exp_cycle_q.push_back(cycle);          // cycle in which accept is high
		@(negedge clk);                        // accepted at the edge just passed
		lookup_valid = 1'b0;
	endtask

	// drain all credits first so the hold starts from a full counter
	task automatic hold_credits(input int base);
		while (exp_hit_q.size() != 0 || owed != 0 || result_credit)
			@(negedge clk);
		hold_left = int'(testdata[base+1]);
		check_ready(1'b1);
	endtask

	initial begin
		wait (timeout_limit > 0);
		while (cycle < timeout_limit)
			@(posedge clk);
		$display("timeout: run still busy after %0d cycles", cycle);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		int ln;
		int base;
		int assert_fails;
		reset         = 1'b1;
		wr_valid      = 1'b0;
		wr_index      = '0;
		wr_field      = table_pkg::FIELD_OFS;
		wr_data       = '0;
		lookup_valid  = 1'b0;
		pixel_x       = '0;
		pixel_y       = '0;
		result_credit = 1'b0;
		for (ln = 0; ln < MAX_LINES * LINE_WORDS; ln++)
			testdata[ln] = 32'hdead_0000 | ln;  // never a legal op code
		$readmemh("sim/sprite_testdata.txt", testdata);
		while (num_lines < MAX_LINES && testdata[num_lines*LINE_WORDS] inside {1, 2, 3, 4})
			num_lines++;
		timeout_limit = num_lines * 20 + 200;

		repeat (8) @(negedge clk);
		reset = 1'b0;
		check_ack(1'b0);
		check_ready(1'b1);
		if (result_valid !== 1'b0)
			report_error("result_valid high after reset");

		for (ln = 0; ln < num_lines; ln++) begin
			base = ln * LINE_WORDS;
			case (testdata[base])
				1: write_field(base);
				2: issue_lookup(base);
				3: hold_credits(base);
				default: check_ready(testdata[base+1][0]);
			endcase
		end
		while (exp_hit_q.size() != 0)
			@(negedge clk);
		repeat (4) @(negedge clk);

		assert_fails = u_sprite_table.u_sprite_result.u_props.fail_count;
		$display("checks %0d, errors %0d, assertion failures %0d",
			check_count, error_count, assert_fails);
		if (error_count == 0 && assert_fails == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/sprite_testdata.txt ====
// columns (hex): op a b c d e; op 1 write: index field data ack 0; op 2 lookup: x y hit index ofs
// op 3 hold credits: cycles; op 4 ready check: expected; op 0 ends the list
// empty table
2 000 000 0 00 000
2 064 032 0 00 000
// entry 5 at x 100, y 40, offset 1a3, spare bits set in each word
1 05 0 ffffffa3 1 0
1 05 1 0ffc51ff 1 0
1 05 2 f193ffff 1 0
2 064 028 1 05 1a3
2 064 03b 1 05 1a3
2 064 027 0 00 000
2 064 03c 0 00 000
2 063 02d 0 00 000
2 065 02d 0 00 000
// illegal selectors
1 05 3 00000000 0 0
1 05 f 0000ffff 0 0
2 064 028 1 05 1a3
// new offset keeps the span, new top line keeps the offset
1 05 0 fffffe55 1 0
2 064 03b 1 05 055
1 05 1 0000c800 1 0
2 064 064 1 05 055
2 064 028 0 00 000
2 064 077 1 05 055
2 064 078 0 00 000
// entry 9 near the last line, no wrap to line 0
1 09 0 000000aa 1 0
1 09 1 0003e800 1 0
1 09 2 000c0000 1 0
2 003 1ff 1 09 0aa
2 003 000 0 00 000
2 003 1f3 0 00 000
// entry 2 overlaps entry 5 on lines 100 to 109
1 02 0 00000111 1 0
1 02 1 0000b400 1 0
1 02 2 01900000 1 0
2 064 069 1 02 111
2 064 06e 1 05 055
2 064 05f 1 02 111
// entry 31 at the right edge
1 1f 0 000001ff 1 0
1 1f 1 00000000 1 0
1 1f 2 0ffc0000 1 0
2 3ff 000 1 1f 1ff
2 3ff 013 1 1f 1ff
2 3ff 014 0 00 000
// credits withheld, four lookups use them up
3 0c 0 0 0 0
2 064 069 1 02 111
2 003 1ff 1 09 0aa
2 064 077 1 05 055
2 000 000 0 00 000
4 0 0 0 0 0
// waits for returned credits
2 3ff 005 1 1f 1ff
2 064 064 1 02 111
2 064 073 1 05 055
0 0 0 0 0 0

// ==== list.f ====
rtl/sprite_pkg.sv
rtl/table_pkg.sv
rtl/lookup_if.sv
rtl/sprite_regs.sv
rtl/sprite_match.sv
rtl/sprite_result.sv
rtl/sprite_table.sv
sim/sprite_table_props.sv
sim/tb_sprite_table.sv
